/* csr_unit.f */
+incdir+tb
src/csr_pkg.sv
src/trap_ctrl.sv
src/csr_timer.sv
src/scratch_regs.sv
src/csr_unit.sv
tb/csr_unit_tb.sv

/* Makefile */
sim:
	verilator --binary --timing --assert --top-module csr_unit_tb -f csr_unit.f -o csr_unit_tb
	./obj_dir/csr_unit_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* tb/csr_unit_cases.svh */
`ifndef CSR_UNIT_CASES_SVH
`define CSR_UNIT_CASES_SVH

// columns: name, operation, address, data, expected value, what is compared
task automatic build_table();
    int    seed;
    int    i;
    xlen_t word;
    seed = 41658;

    add_row("crmd reset", OP_READ, ADDR_CRMD, 32'h0, 32'h0000_0008, CHK_RD);
    add_row("estat reset", OP_READ, ADDR_ESTAT, 32'h0, 32'h0, CHK_RD);
    add_row("prmd reset", OP_READ, ADDR_PRMD, 32'h0, 32'h0, CHK_RD);
    add_row("tcfg reset", OP_READ, ADDR_TCFG, 32'h0, 32'h0, CHK_RD);
    add_row("has_int reset", OP_READ, ADDR_CRMD, 32'h0, 32'h0, CHK_INT);
    add_row("plv reset", OP_READ, ADDR_CRMD, 32'h0, 32'h0, CHK_PLV);
    for (i = 0; i < 4; i++) begin
        add_row($sformatf("save%0d reset", i), OP_READ, ADDR_SAVE_BASE + csr_addr_t'(i),
                32'h0, 32'h0, CHK_RD);
    end

    // plv_out follows wr_data during the crmd write itself
    add_row("crmd write plv", OP_WRITE, ADDR_CRMD, 32'hffff_ffff, 32'h3, CHK_PLV);
    add_row("crmd mask", OP_READ, ADDR_CRMD, 32'h0, 32'h0000_01ff, CHK_RD);
    add_row("prmd write", OP_WRITE, ADDR_PRMD, 32'hffff_ffff, 32'h0, CHK_NONE);
    add_row("prmd mask", OP_READ, ADDR_PRMD, 32'h0, 32'h0000_0007, CHK_RD);
    add_row("ectl write", OP_WRITE, ADDR_ECTL, 32'hffff_ffff, 32'h0, CHK_NONE);
    add_row("ectl mask", OP_READ, ADDR_ECTL, 32'h0, 32'h0000_1fff, CHK_RD);
    add_row("eentry write", OP_WRITE, ADDR_EENTRY, 32'hffff_ffff, 32'h0, CHK_NONE);
    add_row("eentry mask", OP_READ, ADDR_EENTRY, 32'h0, 32'hffff_ffc0, CHK_RD);
    add_row("eentry out", OP_READ, ADDR_EENTRY, 32'h0, 32'hffff_ffc0, CHK_EENTRY);
    for (i = 0; i < 4; i++) begin
        word = $random(seed);
        add_row($sformatf("save%0d write", i), OP_WRITE, ADDR_SAVE_BASE + csr_addr_t'(i),
                word, 32'h0, CHK_NONE);
        add_row($sformatf("save%0d read", i), OP_READ, ADDR_SAVE_BASE + csr_addr_t'(i),
                32'h0, word, CHK_RD);
    end

    // datf 1 and datm 2, compared as {datm, datf}
    add_row("crmd dat write", OP_WRITE, ADDR_CRMD, 32'h0000_0120, 32'h0, CHK_NONE);
    add_row("crmd dat fields", OP_READ, ADDR_CRMD, 32'h0, 32'h0000_0009, CHK_DAT);
    add_row("crmd plv3 ie", OP_WRITE, ADDR_CRMD, 32'h0000_0007, 32'h3, CHK_PLV);
    add_row("prmd clear", OP_WRITE, ADDR_PRMD, 32'h0, 32'h0, CHK_NONE);
    add_row("excp plv", OP_EXCP, ADDR_CRMD, 32'h1c00_2340, 32'h0, CHK_PLV);
    add_row("prmd saved", OP_READ, ADDR_PRMD, 32'h0, 32'h0000_0007, CHK_RD);
    add_row("crmd after excp", OP_READ, ADDR_CRMD, 32'h0, 32'h0, CHK_RD);
    add_row("era captured", OP_READ, ADDR_ERA, 32'h0, 32'h1c00_2340, CHK_RD);
    add_row("era out", OP_READ, ADDR_ERA, 32'h0, 32'h1c00_2340, CHK_ERA);
    // esubcode 0x1a5 in bits 30:22, ecode 0xb in bits 21:16
    add_row("estat codes", OP_READ, ADDR_ESTAT, 32'h0, 32'h694b_0000, CHK_RD);
    add_row("ertn plv", OP_ERTN, ADDR_CRMD, 32'h0, 32'h3, CHK_PLV);
    add_row("crmd after ertn", OP_READ, ADDR_CRMD, 32'h0, 32'h0000_0007, CHK_RD);

    add_row("ectl swi0", OP_WRITE, ADDR_ECTL, 32'h0000_0001, 32'h0, CHK_NONE);
    add_row("estat swi0", OP_WRITE, ADDR_ESTAT, 32'h0000_0001, 32'h0, CHK_NONE);
    add_row("has_int swi0", OP_READ, ADDR_CRMD, 32'h0, 32'h1, CHK_INT);
    add_row("estat swi clear", OP_WRITE, ADDR_ESTAT, 32'h0, 32'h0, CHK_NONE);
    // hw line 0 lands in estat bit 2 one edge later
    add_row("hwi0 not yet", OP_INT, ADDR_ESTAT, 32'h1, 32'h694b_0000, CHK_RD);
    add_row("hwi0 sampled", OP_READ, ADDR_ESTAT, 32'h0, 32'h694b_0004, CHK_RD);
    add_row("has_int hwi masked", OP_READ, ADDR_CRMD, 32'h0, 32'h0, CHK_INT);
    add_row("hwi0 off", OP_INT, ADDR_ESTAT, 32'h0, 32'h694b_0004, CHK_RD);

    // initval 5 counts 20 cycles, pending sets 21 edges after the write
    add_row("tcfg one shot", OP_WRITE, ADDR_TCFG, 32'h0000_0015, 32'h0, CHK_NONE);
    add_row("timer before expiry", OP_WAIT, ADDR_ESTAT, 32'd21, 32'h694b_0000, CHK_RD);
    add_row("timer expired", OP_READ, ADDR_ESTAT, 32'h0, 32'h694b_0800, CHK_RD);
    add_row("tval stopped", OP_READ, ADDR_TVAL, 32'h0, 32'hffff_ffff, CHK_RD);
    add_row("ticlr write", OP_WRITE, ADDR_TICLR, 32'h0000_0001, 32'h0, CHK_NONE);
    add_row("estat timer clear", OP_READ, ADDR_ESTAT, 32'h0, 32'h694b_0000, CHK_RD);
endtask

`endif

/* tb/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int WATCH_MARGIN = 50;

    localparam int OP_WRITE = 0;
    localparam int OP_READ  = 1;
    localparam int OP_EXCP  = 2;
    localparam int OP_ERTN  = 3;
    localparam int OP_INT   = 4;
    localparam int OP_WAIT  = 5;

    localparam int CHK_NONE   = 0;
    localparam int CHK_RD     = 1;
    localparam int CHK_INT    = 2;
    localparam int CHK_PLV    = 3;
    localparam int CHK_EENTRY = 4;
    localparam int CHK_ERA    = 5;
    localparam int CHK_DAT    = 6;

    localparam ecode_t    EXC_ECODE = 6'h0b;
    localparam esubcode_t EXC_ESUB  = 9'h1a5;

    logic                clk;
    logic                reset;
    logic                csr_wr_en;
    csr_addr_t           wr_addr;
    xlen_t               wr_data;
    csr_addr_t           rd_addr;
    xlen_t               rd_data;
    logic                excp_flush;
    logic                ertn_flush;
    xlen_t               era_in;
    ecode_t              ecode_in;
    esubcode_t           esubcode_in;
    logic                va_error_in;
    xlen_t               bad_va_in;
    logic [HW_INT_W-1:0] interrupt;
    logic                has_int;
    plv_t                plv_out;
    xlen_t               eentry_out;
    xlen_t               era_out;
    logic [1:0]          datf_out;
    logic [1:0]          datm_out;

    // one entry per table row in each queue
    string     row_name [$];
    int        row_op [$];
    csr_addr_t row_addr [$];
    xlen_t     row_data [$];
    xlen_t     row_exp [$];
    int        row_chk [$];

    bit table_ready = 1'b0;
    int watchdog_cycles;

    csr_unit #(
        .NUM_SAVE (4)
    ) csr_unit_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_row(input string name, input int op, input csr_addr_t addr,
                           input xlen_t data, input xlen_t expected, input int chk);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_exp.push_back(expected);
        row_chk.push_back(chk);
    endtask

    `include "csr_unit_cases.svh"

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // drive 1 ns after the edge, sample 1 ns before the next one
    task automatic apply_row(input int idx);
        int cycles;
        int k;
        cycles = 1;
        @(posedge clk);
        #1;
        csr_wr_en  = 1'b0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        rd_addr    = row_addr[idx];
        case (row_op[idx])
            OP_WRITE: begin
                csr_wr_en = 1'b1;
                wr_addr   = row_addr[idx];
                wr_data   = row_data[idx];
            end
            OP_EXCP: begin
                excp_flush  = 1'b1;
                era_in      = row_data[idx];
                ecode_in    = EXC_ECODE;
                esubcode_in = EXC_ESUB;
            end
            OP_ERTN: ertn_flush = 1'b1;
            OP_INT:  interrupt = row_data[idx][HW_INT_W-1:0];
            OP_WAIT: cycles = int'(row_data[idx]);
            default: ;
        endcase
        for (k = 1; k < cycles; k++) begin
            @(posedge clk);
            #1;
        end
        #2;
        case (row_chk[idx])
            CHK_RD:     check_value(row_name[idx], row_exp[idx], rd_data);
            CHK_INT:    check_value(row_name[idx], row_exp[idx], {31'b0, has_int});
            CHK_PLV:    check_value(row_name[idx], row_exp[idx], {30'b0, plv_out});
            CHK_EENTRY: check_value(row_name[idx], row_exp[idx], eentry_out);
            CHK_ERA:    check_value(row_name[idx], row_exp[idx], era_out);
            CHK_DAT:    check_value(row_name[idx], row_exp[idx],
                                    {28'b0, datm_out, datf_out});
            default: ;
        endcase
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_cycles * CLK_PERIOD);
        $display("Timeout: the table did not finish within %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int max_wait;
        clk         = 1'b0;
        reset       = 1'b1;
        csr_wr_en   = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        rd_addr     = '0;
        excp_flush  = 1'b0;
        ertn_flush  = 1'b0;
        era_in      = '0;
        ecode_in    = '0;
        esubcode_in = '0;
        va_error_in = 1'b0;
        bad_va_in   = '0;
        interrupt   = '0;
        build_table();
        max_wait = 0;
        foreach (row_op[i]) begin
            if (row_op[i] == OP_WAIT && int'(row_data[i]) > max_wait) begin
                max_wait = int'(row_data[i]);
            end
        end
        watchdog_cycles = RESET_CYCLES + row_op.size() + max_wait + WATCH_MARGIN;
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (row_op[i]) begin
            apply_row(i);
        end
        @(posedge clk);
        #1;
        csr_wr_en  = 1'b0;
        excp_flush = 1'b0;
        ertn_flush = 1'b0;
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* src/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_wr_en,
    input  csr_addr_t           wr_addr,
    input  xlen_t               wr_data,
    input  csr_addr_t           rd_addr,
    output xlen_t               rd_data,
    input  logic                excp_flush,
    input  logic                ertn_flush,
    input  xlen_t               era_in,
    input  ecode_t              ecode_in,
    input  esubcode_t           esubcode_in,
    input  logic                va_error_in,
    input  xlen_t               bad_va_in,
    input  logic [HW_INT_W-1:0] interrupt,
    output logic                has_int,
    output plv_t                plv_out,
    output xlen_t               eentry_out,
    output xlen_t               era_out,
    output logic [1:0]          datf_out,
    output logic [1:0]          datm_out
);

    xlen_t trap_rd_data;
    xlen_t timer_rd_data;
    xlen_t save_rd_data;
    logic  timer_pending;

    trap_ctrl trap_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .csr_wr_en     (csr_wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr),
        .rd_data       (trap_rd_data),
        .excp_flush    (excp_flush),
        .ertn_flush    (ertn_flush),
        .era_in        (era_in),
        .ecode_in      (ecode_in),
        .esubcode_in   (esubcode_in),
        .va_error_in   (va_error_in),
        .bad_va_in     (bad_va_in),
        .interrupt     (interrupt),
        .timer_pending (timer_pending),
        .has_int       (has_int),
        .plv_out       (plv_out),
        .eentry_out    (eentry_out),
        .era_out       (era_out),
        .datf_out      (datf_out),
        .datm_out      (datm_out)
    );

    csr_timer csr_timer_i (
        .clk           (clk),
        .reset         (reset),
        .csr_wr_en     (csr_wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr),
        .rd_data       (timer_rd_data),
        .timer_pending (timer_pending)
    );

    scratch_regs #(
        .NUM_SAVE (NUM_SAVE)
    ) scratch_regs_i (
        .clk       (clk),
        .reset     (reset),
        .csr_wr_en (csr_wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (save_rd_data)
    );

    // blocks return zero for addresses they do not own
    assign rd_data = trap_rd_data | timer_rd_data | save_rd_data;

endmodule

/* src/scratch_regs.sv */
`timescale 1ns/1ps

module scratch_regs import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      csr_wr_en,
    input  csr_addr_t wr_addr,
    input  xlen_t     wr_data,
    input  csr_addr_t rd_addr,
    output xlen_t     rd_data
);

    xlen_t save_q [NUM_SAVE];

    // save regs sit at consecutive csr numbers
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (reset) begin
                save_q[i] <= '0;
            end else if (csr_wr_en && (wr_addr == ADDR_SAVE_BASE + csr_addr_t'(i))) begin
                save_q[i] <= wr_data;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (rd_addr == ADDR_SAVE_BASE + csr_addr_t'(i)) begin
                rd_data = save_q[i];
            end
        end
    end

endmodule

/* src/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      csr_wr_en,
    input  csr_addr_t wr_addr,
    input  xlen_t     wr_data,
    input  csr_addr_t rd_addr,
    output xlen_t     rd_data,
    output logic      timer_pending
);

    xlen_t tcfg;
    xlen_t tval;
    logic  timer_en;
    xlen_t reload_val;
    logic  expire;

    wire tcfg_wen  = csr_wr_en && (wr_addr == ADDR_TCFG);
    wire ticlr_wen = csr_wr_en && (wr_addr == ADDR_TICLR);

    assign reload_val = {tcfg[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b00};
    assign expire     = timer_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg     <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_wen) begin
            tcfg     <= wr_data;
            timer_en <= wr_data[TCFG_EN];
        end else if (expire) begin
            // one-shot mode stops here
            timer_en <= tcfg[TCFG_PERIODIC];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tval <= '0;
        end else if (tcfg_wen) begin
            tval <= {wr_data[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b00};
        end else if (timer_en) begin
            if (tval != '0) begin
                tval <= tval - 32'd1;
            end else begin
                tval <= tcfg[TCFG_PERIODIC] ? reload_val : '1;
            end
        end
    end

    // clear from ticlr beats a same-cycle expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
        end else if (ticlr_wen && wr_data[TICLR_CLR]) begin
            timer_pending <= 1'b0;
        end else if (expire) begin
            timer_pending <= 1'b1;
        end
    end

    // ticlr reads zero
    always_comb begin
        case (rd_addr)
            ADDR_TCFG: rd_data = tcfg;
            ADDR_TVAL: rd_data = tval;
            default:   rd_data = '0;
        endcase
    end

    a_tval_hold: assert property (@(posedge clk) disable iff (reset)
        (!tcfg[TCFG_EN] && !tcfg_wen) |=> $stable(tval));

endmodule

/* src/trap_ctrl.sv */
`timescale 1ns/1ps

module trap_ctrl import csr_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_wr_en,
    input  csr_addr_t           wr_addr,
    input  xlen_t               wr_data,
    input  csr_addr_t           rd_addr,
    output xlen_t               rd_data,
    input  logic                excp_flush,
    input  logic                ertn_flush,
    input  xlen_t               era_in,
    input  ecode_t              ecode_in,
    input  esubcode_t           esubcode_in,
    input  logic                va_error_in,
    input  xlen_t               bad_va_in,
    input  logic [HW_INT_W-1:0] interrupt,
    input  logic                timer_pending,
    output logic                has_int,
    output plv_t                plv_out,
    output xlen_t               eentry_out,
    output xlen_t               era_out,
    output logic [1:0]          datf_out,
    output logic [1:0]          datm_out
);

    logic [CRMD_DATM_HI:0]         crmd;
    logic [PRMD_PIE:0]             prmd;
    logic [LIE_W-1:0]              ectl;
    logic [ESTAT_SWI_HI:0]         swi;
    logic [HW_INT_W-1:0]           hwi;
    ecode_t                        ecode;
    esubcode_t                     esubcode;
    xlen_t                         era;
    xlen_t                         badv;
    logic [31:EENTRY_ALIGN]        eentry;
    logic [LIE_W-1:0]              int_pending;
    xlen_t                         estat_word;

    wire crmd_wen   = csr_wr_en && (wr_addr == ADDR_CRMD);
    wire prmd_wen   = csr_wr_en && (wr_addr == ADDR_PRMD);
    wire ectl_wen   = csr_wr_en && (wr_addr == ADDR_ECTL);
    wire estat_wen  = csr_wr_en && (wr_addr == ADDR_ESTAT);
    wire era_wen    = csr_wr_en && (wr_addr == ADDR_ERA);
    wire badv_wen   = csr_wr_en && (wr_addr == ADDR_BADV);
    wire eentry_wen = csr_wr_en && (wr_addr == ADDR_EENTRY);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= CRMD_RESET[CRMD_DATM_HI:0];
        end else if (excp_flush) begin
            crmd[CRMD_PLV_HI:CRMD_PLV_LO] <= '0;
            crmd[CRMD_IE]                 <= 1'b0;
        end else if (ertn_flush) begin
            crmd[CRMD_PLV_HI:CRMD_PLV_LO] <= prmd[PRMD_PPLV_HI:PRMD_PPLV_LO];
            crmd[CRMD_IE]                 <= prmd[PRMD_PIE];
        end else if (crmd_wen) begin
            crmd <= wr_data[CRMD_DATM_HI:0];
        end
    end

    // prmd keeps the pre-exception plv/ie
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd <= {crmd[CRMD_IE], crmd[CRMD_PLV_HI:CRMD_PLV_LO]};
        end else if (prmd_wen) begin
            prmd <= wr_data[PRMD_PIE:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl     <= '0;
            swi      <= '0;
            hwi      <= '0;
            ecode    <= '0;
            esubcode <= '0;
            eentry   <= '0;
        end else begin
            hwi <= interrupt;
            if (ectl_wen) begin
                ectl <= wr_data[LIE_W-1:0];
            end
            if (excp_flush) begin
                ecode    <= ecode_in;
                esubcode <= esubcode_in;
            end else if (estat_wen) begin
                swi <= wr_data[ESTAT_SWI_HI:ESTAT_SWI_LO];
            end
            if (eentry_wen) begin
                eentry <= wr_data[31:EENTRY_ALIGN];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era  <= '0;
            badv <= '0;
        end else begin
            if (excp_flush) begin
                era <= era_in;
            end else if (era_wen) begin
                era <= wr_data;
            end
            // software write beats a faulting address
            if (badv_wen) begin
                badv <= wr_data;
            end else if (va_error_in) begin
                badv <= bad_va_in;
            end
        end
    end

    always_comb begin
        int_pending = '0;
        int_pending[ESTAT_SWI_HI:ESTAT_SWI_LO] = swi;
        int_pending[ESTAT_HWI_HI:ESTAT_HWI_LO] = hwi;
        int_pending[ESTAT_TI]                  = timer_pending;
        estat_word = '0;
        estat_word[LIE_W-1:0]                    = int_pending;
        estat_word[ESTAT_ECODE_HI:ESTAT_ECODE_LO] = ecode;
        estat_word[ESTAT_ESUB_HI:ESTAT_ESUB_LO]   = esubcode;
    end

    always_comb begin
        rd_data = '0;
        case (rd_addr)
            ADDR_CRMD:   rd_data[CRMD_DATM_HI:0] = crmd;
            ADDR_PRMD:   rd_data[PRMD_PIE:0]     = prmd;
            ADDR_ECTL:   rd_data[LIE_W-1:0]      = ectl;
            ADDR_ESTAT:  rd_data                 = estat_word;
            ADDR_ERA:    rd_data                 = era;
            ADDR_BADV:   rd_data                 = badv;
            ADDR_EENTRY: rd_data                 = eentry_out;
            default:     rd_data                 = '0;
        endcase
    end

    assign has_int = (|(ectl & int_pending)) && crmd[CRMD_IE];

    // fetch sees the new level in the flush cycle itself
    assign plv_out = excp_flush ? plv_t'(0) :
                     ertn_flush ? prmd[PRMD_PPLV_HI:PRMD_PPLV_LO] :
                     crmd_wen   ? wr_data[CRMD_PLV_HI:CRMD_PLV_LO] :
                                  crmd[CRMD_PLV_HI:CRMD_PLV_LO];

    assign eentry_out = {eentry, {EENTRY_ALIGN{1'b0}}};
    assign era_out    = era;
    assign datf_out   = crmd[CRMD_DATF_HI:CRMD_DATF_LO];
    assign datm_out   = crmd[CRMD_DATM_HI:CRMD_DATM_LO];

    a_flush_onehot: assert property (@(posedge clk) disable iff (reset)
        !(excp_flush && ertn_flush));

    // forwarded level is the one crmd holds after the edge
    a_plv_forward: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> crmd[CRMD_PLV_HI:CRMD_PLV_LO] == $past(plv_out));

endmodule

/* src/csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // csr numbers
    localparam csr_addr_t ADDR_CRMD      = 14'h0;
    localparam csr_addr_t ADDR_PRMD      = 14'h1;
    localparam csr_addr_t ADDR_ECTL      = 14'h4;
    localparam csr_addr_t ADDR_ESTAT     = 14'h5;
    localparam csr_addr_t ADDR_ERA       = 14'h6;
    localparam csr_addr_t ADDR_BADV      = 14'h7;
    localparam csr_addr_t ADDR_EENTRY    = 14'hc;
    localparam csr_addr_t ADDR_SAVE_BASE = 14'h30;
    localparam csr_addr_t ADDR_TCFG      = 14'h41;
    localparam csr_addr_t ADDR_TVAL      = 14'h42;
    localparam csr_addr_t ADDR_TICLR     = 14'h44;

    // crmd fields
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATF_HI = 6;
    localparam int CRMD_DATM_LO = 7;
    localparam int CRMD_DATM_HI = 8;
    localparam xlen_t CRMD_RESET = 32'h8;

    localparam int PRMD_PPLV_LO = 0;
    localparam int PRMD_PPLV_HI = 1;
    localparam int PRMD_PIE     = 2;

    // estat layout
    localparam int ESTAT_SWI_LO   = 0;
    localparam int ESTAT_SWI_HI   = 1;
    localparam int ESTAT_HWI_LO   = 2;
    localparam int ESTAT_HWI_HI   = 10;
    localparam int ESTAT_TI       = 11;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_ESUB_LO  = 22;
    localparam int ESTAT_ESUB_HI  = 30;

    localparam int LIE_W    = 13;
    localparam int HW_INT_W = 9;

    localparam int TCFG_EN         = 0;
    localparam int TCFG_PERIODIC   = 1;
    localparam int TCFG_INITVAL_LO = 2;
    localparam int TCFG_INITVAL_HI = 31;
    localparam int TICLR_CLR       = 0;

    // low eentry bits are hardwired to zero
    localparam int EENTRY_ALIGN = 6;

    localparam ecode_t ECODE_INT = 6'h0;
    localparam ecode_t ECODE_ADE = 6'h8;
    localparam ecode_t ECODE_ALE = 6'h9;
    localparam ecode_t ECODE_SYS = 6'hb;
    localparam ecode_t ECODE_BRK = 6'hc;
    localparam ecode_t ECODE_INE = 6'hd;

endpackage
